/* rtl/book_cfg_pkg.sv */
// Sizes and command encodings shared by the price-level book pipeline
// Imported by every RTL block and by the types package
package book_cfg_pkg;

  // Products and per-product level list
  localparam int PROD_N    = 8;
  localparam int PROD_ID_W = 3;
  localparam int LEVEL_N   = 4;

  // Price key and volume widths
  localparam int KEY_W = 8;
  localparam int VOL_W = 12;

  // Update commands
  localparam int CMD_W = 1;
  localparam logic [CMD_W-1:0] CMD_ADD    = 1'b0;
  localparam logic [CMD_W-1:0] CMD_REMOVE = 1'b1;

endpackage

/* rtl/book_types_pkg.sv */
// Packed structs carried through the book update pipeline
// Update and notify buses, per-product level state and write-back
package book_types_pkg;

  import book_cfg_pkg::*;

  // Update bus, 25 bits
  typedef struct packed {
    logic                 vld;
    logic [PROD_ID_W-1:0] prod_id;
    logic [CMD_W-1:0]     cmd;
    logic [KEY_W-1:0]     key;
    logic [VOL_W-1:0]     size;
  } upd_t;

  // Level list of one product, 84 bits
  typedef struct packed {
    logic [LEVEL_N-1:0]            vld;
    logic [LEVEL_N-1:0][KEY_W-1:0] key;
    logic [LEVEL_N-1:0][VOL_W-1:0] volume;
  } level_state_t;

  // Write-back into the state table, 88 bits
  typedef struct packed {
    logic                 vld;
    logic [PROD_ID_W-1:0] prod_id;
    level_state_t         state;
  } wrbk_t;

  // Key compare result, 10 bits
  typedef struct packed {
    logic               hit;
    logic               full;
    logic [LEVEL_N-1:0] hit_sel;
    logic [LEVEL_N-1:0] free_sel;
  } match_t;

  // Notify message, 24 bits
  typedef struct packed {
    logic                 vld;
    logic [PROD_ID_W-1:0] prod_id;
    logic [KEY_W-1:0]     key;
    logic [VOL_W-1:0]     volume;
  } notify_t;

endpackage

/* rtl/book_state_ram.sv */
// Per-product level state table
// One registered read port and one write port fed by the write-back stage
`timescale 1ns/100ps

module book_state_ram
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  logic                 clk
  , input  logic                 i_rst_n
  // Read side
  , input  logic                 i_ren
  , input  logic [PROD_ID_W-1:0] i_raddr
  , output level_state_t         o_rdata
  // Write side
  , input  wrbk_t                i_wrbk
);

  level_state_t mem [PROD_N];

  // Reset only empties the level lists, keys and volumes keep their contents
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < PROD_N; i++) begin
        mem[i].vld <= '0;
      end
    end else if (i_wrbk.vld) begin
      mem[i_wrbk.prod_id] <= i_wrbk.state;
    end
  end

  // Read returns the old entry on a same-edge write
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

/* rtl/book_fwd.sv */
// Write-back collision detection and state forwarding
// S1 side kills the table read, S2 side picks the freshest state
`timescale 1ns/100ps

module book_fwd
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  upd_t                 i_s1_upd
  , input  upd_t                 i_s2_upd
  // Next write-back and registered write-back
  , input  wrbk_t                i_wrbk_cur
  , input  wrbk_t                i_wrbk_prior
  // Flagged state latched into S2
  , input  wrbk_t                i_s2_prior
  , input  level_state_t         i_ram_rdata
  , output logic                 o_ren
  , output logic [PROD_ID_W-1:0] o_raddr
  , output logic                 o_s1_collide
  , output level_state_t         o_s1_fwd_state
  , output level_state_t         o_s3_state
);

  logic s1_hit_cur;
  logic s1_hit_prior;
  logic s2_hit_cur;

  // S1 against both write-backs, either lands in the table too late
  assign s1_hit_cur   = i_wrbk_cur.vld & (i_wrbk_cur.prod_id == i_s1_upd.prod_id);
  assign s1_hit_prior = i_wrbk_prior.vld & (i_wrbk_prior.prod_id == i_s1_upd.prod_id);
  assign o_s1_collide = s1_hit_cur | s1_hit_prior;

  // Newer write-back wins when both collide
  assign o_s1_fwd_state = s1_hit_cur ? i_wrbk_cur.state : i_wrbk_prior.state;

  // Read is killed on collision
  assign o_ren   = i_s1_upd.vld & ~o_s1_collide;
  assign o_raddr = i_s1_upd.prod_id;

  assign s2_hit_cur = i_wrbk_cur.vld & (i_wrbk_cur.prod_id == i_s2_upd.prod_id);

  // Fixed preference: current write-back, then flagged prior, then RAM
  always_comb begin
    if (s2_hit_cur) begin
      o_s3_state = i_wrbk_cur.state;
    end else if (i_s2_prior.vld) begin
      o_s3_state = i_s2_prior.state;
    end else begin
      o_s3_state = i_ram_rdata;
    end
  end

endmodule

/* rtl/book_key_match.sv */
// Key compare against one product's level list
// Gives the hit level, the full flag and the lowest free slot
`timescale 1ns/100ps

module book_key_match
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  logic [KEY_W-1:0] i_key
  , input  level_state_t     i_state
  , output match_t           o_match
);

  logic [LEVEL_N-1:0] hit_sel;
  logic [LEVEL_N-1:0] free_sel;
  logic               found;

  // Keys are unique within a list so at most one level hits
  always_comb begin
    for (int i = 0; i < LEVEL_N; i++) begin
      hit_sel[i] = i_state.vld[i] & (i_state.key[i] == i_key);
    end
  end

  // Lowest free slot, one-hot
  always_comb begin
    free_sel = '0;
    found    = 1'b0;
    for (int i = 0; i < LEVEL_N; i++) begin
      if (!i_state.vld[i] && !found) begin
        free_sel[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  assign o_match.hit      = |hit_sel;
  assign o_match.full     = &i_state.vld;
  assign o_match.hit_sel  = hit_sel;
  assign o_match.free_sel = free_sel;

endmodule

/* rtl/book_level_exe.sv */
// Execute stage of the book update
// Applies ADD or REMOVE to one level and builds the notify message
`timescale 1ns/100ps

module book_level_exe
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  upd_t         i_upd
  , input  match_t       i_match
  , input  level_state_t i_state
  , output level_state_t o_state_nxt
  , output notify_t      o_notify
);

  logic [LEVEL_N-1:0] sel;
  logic               do_add;
  logic               do_alloc;
  logic               do_remove;
  logic [VOL_W-1:0]   cur_vol;
  logic [VOL_W-1:0]   new_vol;

  // Command decode
  assign do_add    = (i_upd.cmd == CMD_ADD) & i_match.hit;
  assign do_alloc  = (i_upd.cmd == CMD_ADD) & ~i_match.hit & ~i_match.full;
  assign do_remove = (i_upd.cmd == CMD_REMOVE) & i_match.hit;

  // Level to touch, none on a rejected ADD or a missed REMOVE
  assign sel = do_alloc ? i_match.free_sel : i_match.hit_sel;

  // Volume of the hit level
  always_comb begin
    cur_vol = '0;
    for (int i = 0; i < LEVEL_N; i++) begin
      if (i_match.hit_sel[i]) begin
        cur_vol = i_state.volume[i];
      end
    end
  end

  // New volume, REMOVE clamps at zero
  always_comb begin
    if (do_alloc) begin
      new_vol = i_upd.size;
    end else if (do_add) begin
      new_vol = cur_vol + i_upd.size;
    end else if (cur_vol > i_upd.size) begin
      new_vol = cur_vol - i_upd.size;
    end else begin
      new_vol = '0;
    end
  end

  always_comb begin
    o_state_nxt = i_state;
    for (int i = 0; i < LEVEL_N; i++) begin
      if (sel[i] && (do_add || do_alloc || do_remove)) begin
        o_state_nxt.key[i]    = i_upd.key;
        o_state_nxt.volume[i] = new_vol;
        // Level at zero after REMOVE goes back to the free pool
        o_state_nxt.vld[i]    = ~(do_remove & (new_vol == '0));
      end
    end
  end

  // One message per changed level
  assign o_notify.vld     = i_upd.vld & (do_add | do_alloc | do_remove);
  assign o_notify.prod_id = i_upd.prod_id;
  assign o_notify.key     = i_upd.key;
  assign o_notify.volume  = new_vol;

endmodule

/* rtl/book_update_pipe.sv */
// Staged book update datapath
// S1 latch, S2 lookup and forward, S3 compare, S4 execute, then write-back
// Talks to the state table through a read port and the write-back bus
`timescale 1ns/100ps

module book_update_pipe
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  logic                 clk
  , input  logic                 i_rst_n
  , input  upd_t                 i_upd
  , output logic                 o_ren
  , output logic [PROD_ID_W-1:0] o_raddr
  , input  level_state_t         i_rdata
  , output wrbk_t                o_wrbk
  , output notify_t              o_notify
);

  upd_t         s1_upd_r;
  upd_t         s2_upd_r;
  wrbk_t        s2_prior_r;
  upd_t         s3_upd_r;
  level_state_t s3_state_r;
  upd_t         s4_upd_r;
  level_state_t s4_state_r;
  match_t       s4_match_r;
  wrbk_t        wrbk_r;
  notify_t      s5_notify_r;
  notify_t      notify_r;

  logic         s1_collide;
  level_state_t s1_fwd_state;
  level_state_t s3_state_sel;
  level_state_t s3_state;
  match_t       s3_match;
  level_state_t s4_state_nxt;
  notify_t      s4_notify;
  wrbk_t        wrbk_nxt;

  // S1 input latch
  always_ff @(posedge clk) begin
    if (i_upd.vld) begin
      s1_upd_r <= i_upd;
    end
    if (!i_rst_n) begin
      s1_upd_r.vld <= 1'b0;
    end else begin
      s1_upd_r.vld <= i_upd.vld;
    end
  end

  book_fwd u_fwd (
      .i_s1_upd       (s1_upd_r)
    , .i_s2_upd       (s2_upd_r)
    , .i_wrbk_cur     (wrbk_nxt)
    , .i_wrbk_prior   (wrbk_r)
    , .i_s2_prior     (s2_prior_r)
    , .i_ram_rdata    (i_rdata)
    , .o_ren          (o_ren)
    , .o_raddr        (o_raddr)
    , .o_s1_collide   (s1_collide)
    , .o_s1_fwd_state (s1_fwd_state)
    , .o_s3_state     (s3_state_sel)
  );

  // S2 holds the update and the flagged write-back copy
  always_ff @(posedge clk) begin
    if (s1_upd_r.vld) begin
      s2_upd_r         <= s1_upd_r;
      s2_prior_r.state <= s1_fwd_state;
      s2_prior_r.prod_id <= s1_upd_r.prod_id;
    end
    if (!i_rst_n) begin
      s2_upd_r.vld   <= 1'b0;
      s2_prior_r.vld <= 1'b0;
    end else begin
      s2_upd_r.vld   <= s1_upd_r.vld;
      s2_prior_r.vld <= s1_upd_r.vld & s1_collide;
    end
  end

  // S3 holds the selected state
  always_ff @(posedge clk) begin
    if (s2_upd_r.vld) begin
      s3_upd_r   <= s2_upd_r;
      s3_state_r <= s3_state_sel;
    end
    if (!i_rst_n) begin
      s3_upd_r.vld <= 1'b0;
    end else begin
      s3_upd_r.vld <= s2_upd_r.vld;
    end
  end

  // Same product one stage ahead in S4 overrides the latched state
  assign s3_state = (s4_upd_r.vld && (s4_upd_r.prod_id == s3_upd_r.prod_id)) ?
                    s4_state_nxt : s3_state_r;

  book_key_match u_key_match (
      .i_key   (s3_upd_r.key)
    , .i_state (s3_state)
    , .o_match (s3_match)
  );

  // S4 holds the state and the compare result
  always_ff @(posedge clk) begin
    if (s3_upd_r.vld) begin
      s4_upd_r   <= s3_upd_r;
      s4_state_r <= s3_state;
      s4_match_r <= s3_match;
    end
    if (!i_rst_n) begin
      s4_upd_r.vld <= 1'b0;
    end else begin
      s4_upd_r.vld <= s3_upd_r.vld;
    end
  end

  book_level_exe u_level_exe (
      .i_upd       (s4_upd_r)
    , .i_match     (s4_match_r)
    , .i_state     (s4_state_r)
    , .o_state_nxt (s4_state_nxt)
    , .o_notify    (s4_notify)
  );

  // Next write-back, also the current forwarding source
  assign wrbk_nxt.vld     = s4_upd_r.vld;
  assign wrbk_nxt.prod_id = s4_upd_r.prod_id;
  assign wrbk_nxt.state   = s4_state_nxt;

  // Write-back stage and notify output, the notify trails by one register
  always_ff @(posedge clk) begin
    if (wrbk_nxt.vld) begin
      wrbk_r <= wrbk_nxt;
    end
    if (s4_notify.vld) begin
      s5_notify_r <= s4_notify;
    end
    if (s5_notify_r.vld) begin
      notify_r <= s5_notify_r;
    end
    if (!i_rst_n) begin
      wrbk_r.vld      <= 1'b0;
      s5_notify_r.vld <= 1'b0;
      notify_r.vld    <= 1'b0;
    end else begin
      wrbk_r.vld      <= wrbk_nxt.vld;
      s5_notify_r.vld <= s4_notify.vld;
      notify_r.vld    <= s5_notify_r.vld;
    end
  end

  assign o_wrbk   = wrbk_r;
  assign o_notify = notify_r;

endmodule

/* rtl/book_update_top.sv */
// Top level of the book update engine
// Update bus in, notify bus out, state table kept inside
`timescale 1ns/100ps

module book_update_top
  import book_cfg_pkg::*;
  import book_types_pkg::*;
(
    input  logic    clk
  , input  logic    i_rst_n
  , input  upd_t    i_upd
  , output notify_t o_notify
);

  logic                 ren;
  logic [PROD_ID_W-1:0] raddr;
  level_state_t         rdata;
  wrbk_t                wrbk;

  book_update_pipe u_pipe (
      .clk      (clk)
    , .i_rst_n  (i_rst_n)
    , .i_upd    (i_upd)
    , .o_ren    (ren)
    , .o_raddr  (raddr)
    , .i_rdata  (rdata)
    , .o_wrbk   (wrbk)
    , .o_notify (o_notify)
  );

  book_state_ram u_state_ram (
      .clk     (clk)
    , .i_rst_n (i_rst_n)
    , .i_ren   (ren)
    , .i_raddr (raddr)
    , .o_rdata (rdata)
    , .i_wrbk  (wrbk)
  );

endmodule

/* testbench/tb_book_update.sv */
// Testbench for the book update engine
// Reads update vectors, drives them with random idle gaps and checks
// each notify message against the expected queue, in order
`timescale 1ns/100ps

module tb_book_update
  import book_cfg_pkg::*;
  import book_types_pkg::*;
();

  localparam int DRAIN_TIMEOUT = 60;
  localparam int QUIET_CYCLES  = 10;

  logic    clk;
  logic    rst_n;
  upd_t    upd;
  notify_t notify;

  // Vectors as read from the file
  // Expected notify has vld low when none is due
  upd_t    vec_upd[$];
  notify_t vec_exp[$];
  // Notifies still owed by the DUT with the oldest at the front
  notify_t exp_q[$];

  logic [31:0] rng_state = 32'hbb12_d0fb;
  int          checked   = 0;

  book_update_top u_dut (
      .clk      (clk)
    , .i_rst_n  (rst_n)
    , .i_upd    (upd)
    , .o_notify (notify)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("ERROR at %0d ns: %s", $time, why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_notify(input notify_t act, input notify_t exp);
    string got_s;
    string exp_s;
    if (act !== exp) begin
      got_s = $sformatf("vld %b prod %0d key %h vol %h",
                        act.vld, act.prod_id, act.key, act.volume);
      exp_s = $sformatf("vld %b prod %0d key %h vol %h",
                        exp.vld, exp.prod_id, exp.key, exp.volume);
      $display("CHECK FAILED at %0d ns: o_notify got %s, expected %s",
               $time, got_s, exp_s);
      $display("Test FAILED");
      $fatal(1, "notify compare error");
    end
  endtask

  // One update or idle word per rising edge
  task automatic drive_update(input upd_t u);
    @(posedge clk);
    upd <= u;
  endtask

  task automatic read_vectors();
    int          fd;
    int          rc;
    int          n;
    string       line;
    logic [31:0] f_prod;
    logic [31:0] f_cmd;
    logic [31:0] f_key;
    logic [31:0] f_size;
    logic [31:0] f_exp;
    logic [31:0] f_ekey;
    logic [31:0] f_evol;
    upd_t        u;
    notify_t     e;
    fd = $fopen("testbench/update_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/update_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      f_prod, f_cmd, f_key, f_size, f_exp, f_ekey, f_evol);
          // Comment and blank lines give fewer fields
          if (n == 7) begin
            u.vld     = 1'b1;
            u.prod_id = f_prod[PROD_ID_W-1:0];
            u.cmd     = f_cmd[CMD_W-1:0];
            u.key     = f_key[KEY_W-1:0];
            u.size    = f_size[VOL_W-1:0];
            e.vld     = f_exp[0];
            e.prod_id = f_prod[PROD_ID_W-1:0];
            e.key     = f_ekey[KEY_W-1:0];
            e.volume  = f_evol[VOL_W-1:0];
            vec_upd.push_back(u);
            vec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Monitor samples on the falling edge away from the DUT's register updates
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && notify.vld) begin
        if (exp_q.size() == 0) begin
          abort_run("o_notify valid while no notify was expected");
        end else begin
          check_notify(notify, exp_q.pop_front());
          checked++;
        end
      end
    end
  end

  initial begin
    int gap;
    int waited;
    upd   = '0;
    rst_n = 1'b0;
    read_vectors();
    if (vec_upd.size() == 0) begin
      abort_run("vector file holds no updates");
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < vec_upd.size(); i++) begin
      // Gap of 0 to 3 idle cycles with zero in most draws
      rng_state = next_rand(rng_state);
      gap = (rng_state[2:0] > 3'd3) ? 0 : int'(rng_state[2:0]);
      for (int g = 0; g < gap; g++) begin
        drive_update('0);
      end
      drive_update(vec_upd[i]);
      if (vec_exp[i].vld) begin
        exp_q.push_back(vec_exp[i]);
      end
    end
    drive_update('0);

    // Drain the expected queue
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    // Quiet window so a stray late notify is still caught
    for (int q = 0; q < QUIET_CYCLES; q++) begin
      @(negedge clk);
    end

    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected notify messages never arrived", exp_q.size()));
    end else begin
      $display("%0d notify messages checked", checked);
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* testbench/update_vectors.txt */
// prod cmd key size expect exp_key exp_vol, all fields hex
// cmd 0 is ADD, 1 is REMOVE; expect 0 means the update gives no notify
1 0 10 005 1 10 005
1 0 20 007 1 20 007
1 0 30 009 1 30 009
1 0 20 003 1 20 00a
1 0 20 001 1 20 00b
1 0 20 002 1 20 00d
1 1 10 002 1 10 003
1 1 10 005 1 10 000
1 0 40 004 1 40 004
1 0 50 006 1 50 006
1 0 60 001 0 00 000
1 1 77 010 0 00 000
1 1 30 009 1 30 000
1 0 60 001 1 60 001
2 0 10 064 1 10 064
3 0 10 0c8 1 10 0c8
2 0 10 001 1 10 065
3 1 10 032 1 10 096
2 0 55 123 1 55 123
2 1 10 0ff 1 10 000
3 0 10 001 1 10 097
5 0 01 001 1 01 001
5 0 02 002 1 02 002
5 0 03 003 1 03 003
5 0 04 004 1 04 004
5 0 05 005 0 00 000
7 0 ff 800 1 ff 800
7 0 ff 7ff 1 ff fff
7 1 ff 001 1 ff ffe
0 1 10 001 0 00 000
1 0 50 001 1 50 007

/* verilog.f */
rtl/book_cfg_pkg.sv
rtl/book_types_pkg.sv
rtl/book_state_ram.sv
rtl/book_fwd.sv
rtl/book_key_match.sv
rtl/book_level_exe.sv
rtl/book_update_pipe.sv
rtl/book_update_top.sv
testbench/tb_book_update.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the book update testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f verilog.f \
  --top-module tb_book_update \
  -Mdir obj_dir \
  -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
